//--- Makefile
# Verilator build and run for the data cache testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f all.f --top-module tb_dcache

run: compile
	./obj_dir/Vtb_dcache | tee sim.log
	grep -q "^>>> PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- all.f
+incdir+.
dcache_pkg.sv
dcache_ifc.sv
dcache_reqbuf.sv
dcache_arrays.sv
dcache_fsm.sv
dcache_top.sv
tb_dcache.sv

//--- dcache_arrays.sv
// tag/valid, line data and lru arrays with hit detection
// refill and byte-merged store writes
`timescale 1ns/100ps
`default_nettype none
`include "dcache_settings.svh"

module dcache_arrays (
    input  wire                   clk,
    input  wire                   rstn,
    input  wire [`DC_ADDR_W-1:0]  req_addr,
    input  wire [`DC_LINE_W-1:0]  mem_rdata,
    rbuf_if.array                 rb,
    array_if.arrays               ar
);

    localparam int SETS = 1 << `DC_INDEX_W;

    logic [`DC_TAG_W-1:0]            tag_mem  [`DC_WAYS][SETS];
    logic [`DC_LINE_W-1:0]           data_mem [`DC_WAYS][SETS];
    logic [`DC_WAYS-1:0][SETS-1:0]   valid_q;
    logic [SETS-1:0]                 lru_q;     // way to replace next

    dcache_pkg::dc_addr_u            req_view;
    logic [`DC_INDEX_W-1:0]          rd_idx_q;
    logic [`DC_INDEX_W-1:0]          wr_idx;
    logic                            wr_way;
    logic [`DC_LINE_W-1:0]           hit_line;
    logic [`DC_LINE_W-1:0]           merged_line;

    function automatic logic [31:0] pick_word(input logic [`DC_LINE_W-1:0] line,
                                              input logic [`DC_OFFSET_W-1:0] w);
        return line[32*w +: 32];
    endfunction

    assign req_view = dcache_pkg::dc_addr_u'(req_addr);
    assign wr_idx   = rb.addr.mem.index;
    assign wr_way   = ar.data_we[1];

    //////////////////////////////////////////////////
    // read side
    //////////////////////////////////////////////////
    assign ar.tag_way0 = {valid_q[0][rd_idx_q], tag_mem[0][rd_idx_q]};
    assign ar.tag_way1 = {valid_q[1][rd_idx_q], tag_mem[1][rd_idx_q]};

    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            ar.hit[w] = valid_q[w][rd_idx_q] && (tag_mem[w][rd_idx_q] == rb.addr.mem.tag);
        end
    end

    assign hit_line     = ar.hit[1] ? data_mem[1][rd_idx_q] : data_mem[0][rd_idx_q];
    assign ar.hit_word  = pick_word(hit_line, rb.addr.mem.word);
    assign ar.line_word = pick_word(mem_rdata, rb.addr.mem.word);
    assign ar.lru_way   = lru_q[rd_idx_q];

    // store data merged into the line held by the written way
    always_comb begin
        int base;
        merged_line = data_mem[wr_way][wr_idx];
        for (int b = 0; b < 4; b++) begin
            base = 32 * int'(rb.addr.mem.word) + 8 * b;
            if (rb.wstrb[b]) begin
                merged_line[base +: 8] = rb.wdata[8*b +: 8];
            end
        end
    end

    //////////////////////////////////////////////////
    // write side
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (ar.data_we[w]) begin
                if (ar.replace) begin
                    data_mem[w][wr_idx] <= mem_rdata;       // whole line
                    tag_mem[w][wr_idx]  <= rb.addr.mem.tag;
                end else begin
                    data_mem[w][wr_idx] <= merged_line;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q  <= '0;
            lru_q    <= '0;
            rd_idx_q <= '0;
        end else begin
            if (ar.rd_index) rd_idx_q <= req_view.mem.index;
            for (int w = 0; w < `DC_WAYS; w++) begin
                if (ar.inval[w]) begin
                    valid_q[w][wr_idx] <= 1'b0;
                end else if (ar.data_we[w] && ar.replace) begin
                    valid_q[w][wr_idx] <= 1'b1;
                end
            end
            // point at the way that was not just used
            if (ar.use_way[0]) begin
                lru_q[wr_idx] <= 1'b1;
            end else if (ar.use_way[1]) begin
                lru_q[wr_idx] <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- dcache_fsm.sv
// main cache controller
// lookup, refill, write-through and cache-op sequencing
`timescale 1ns/100ps
`default_nettype none
`include "dcache_settings.svh"

module dcache_fsm (
    input  wire                   clk,
    input  wire                   rstn,
    input  wire                   req_valid,
    input  wire                   req_is_op,
    output logic                  req_ready,
    output logic                  rsp_valid,
    output logic [31:0]           rsp_rdata,
    output logic                  mem_req,
    output logic                  mem_wr,
    output logic [1:0]            mem_size,
    output logic [3:0]            mem_wstrb,
    output logic [`DC_ADDR_W-1:0] mem_addr,
    output logic [31:0]           mem_wdata,
    input  wire                   mem_addr_ok,
    input  wire                   mem_data_ok,
    rbuf_if.ctrl                  rb,
    array_if.ctrl                 ar
);

    dcache_pkg::dc_state_e state, next_state;
    dcache_pkg::dc_state_e accept_st;   // where a new handshake leads
    logic                  miss;
    logic                  fill_way;
    logic [`DC_WAYS-1:0]   fill_oh;
    logic [`DC_WAYS-1:0]   op_oh;

    assign accept_st = !req_valid ? dcache_pkg::ST_IDLE :
                       req_is_op  ? dcache_pkg::ST_OP : dcache_pkg::ST_LOOKUP;

    assign miss = rb.suc || !(|ar.hit);

    // refill victim, an empty way before the lru way
    assign fill_way = !ar.tag_way0[`DC_TAG_W] ? 1'b0 :
                      !ar.tag_way1[`DC_TAG_W] ? 1'b1 : ar.lru_way;
    assign fill_oh  = fill_way ? 2'b10 : 2'b01;
    assign op_oh    = rb.addr.op.way ? 2'b10 : 2'b01;

    // memory side comes straight off the buffer
    assign mem_size  = 2'd2;    // always a word
    assign mem_wstrb = rb.wstrb;
    assign mem_wdata = rb.wdata;
    assign mem_addr  = {rb.addr.mem.tag, rb.addr.mem.index, rb.addr.mem.word, 2'b00};

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) state <= dcache_pkg::ST_IDLE;
        else       state <= next_state;
    end

    //////////////////////////////////////////////////
    // next state and outputs
    //////////////////////////////////////////////////
    always_comb begin
        next_state  = state;
        req_ready   = 1'b0;
        rsp_valid   = 1'b0;
        rsp_rdata   = (state == dcache_pkg::ST_MISS_R_WAIT) ? ar.line_word : ar.hit_word;
        mem_req     = 1'b0;
        mem_wr      = 1'b0;
        ar.data_we  = '0;
        ar.replace  = 1'b0;
        ar.inval    = '0;
        ar.use_way  = '0;
        case (state)
            dcache_pkg::ST_IDLE: begin
                req_ready  = 1'b1;
                next_state = accept_st;
            end
            dcache_pkg::ST_LOOKUP: begin
                if (rb.suc) ar.inval = ar.hit;     // drop a stale copy
                if (!rb.wr) begin
                    if (miss) begin
                        mem_req    = 1'b1;
                        next_state = mem_addr_ok ? dcache_pkg::ST_MISS_R_WAIT
                                                 : dcache_pkg::ST_MISS_R;
                    end else begin
                        rsp_valid  = 1'b1;         // read hit, keep streaming
                        ar.use_way = ar.hit;
                        req_ready  = 1'b1;
                        next_state = accept_st;
                    end
                end else begin
                    mem_req = 1'b1;                // write-through
                    mem_wr  = 1'b1;
                    if (!miss) begin
                        ar.data_we = ar.hit;
                        ar.use_way = ar.hit;
                    end
                    if (mem_addr_ok) begin
                        req_ready  = 1'b1;
                        next_state = accept_st;
                    end else begin
                        next_state = miss ? dcache_pkg::ST_MISS_W : dcache_pkg::ST_HIT_W;
                    end
                end
            end
            dcache_pkg::ST_OP: begin
                if (rb.is_op) begin
                    case (rb.op)
                        dcache_pkg::OP_INDEX_INIT,
                        dcache_pkg::OP_INDEX_INVAL: begin
                            ar.inval   = op_oh;
                            ar.use_way = {op_oh[0], op_oh[1]};  // next victim
                        end
                        dcache_pkg::OP_HIT_INVAL: ar.inval = ar.hit;
                        default: ;
                    endcase
                end
                next_state = dcache_pkg::ST_IDLE;
            end
            dcache_pkg::ST_HIT_W,
            dcache_pkg::ST_MISS_W: begin
                mem_req = 1'b1;
                mem_wr  = 1'b1;
                if (mem_addr_ok) begin
                    req_ready  = 1'b1;
                    next_state = accept_st;
                end
            end
            dcache_pkg::ST_MISS_R: begin
                mem_req = 1'b1;
                if (mem_addr_ok) next_state = dcache_pkg::ST_MISS_R_WAIT;
            end
            dcache_pkg::ST_MISS_R_WAIT: begin
                if (mem_data_ok) begin
                    rsp_valid  = 1'b1;
                    req_ready  = 1'b1;
                    next_state = accept_st;
                    if (!rb.suc) begin             // uncached loads are not kept
                        ar.data_we = fill_oh;
                        ar.replace = 1'b1;
                        ar.use_way = fill_oh;
                    end
                end
            end
            default: next_state = dcache_pkg::ST_IDLE;
        endcase
        rb.we       = req_ready && req_valid;
        ar.rd_index = rb.we;
    end

endmodule

`default_nettype wire

//--- dcache_ifc.sv
// internal cache interfaces
// rbuf_if links request buffer and controller, array_if links controller and arrays
`timescale 1ns/100ps
`default_nettype none
`include "dcache_settings.svh"

interface rbuf_if;
    logic                    we;      // capture the handshaking request
    dcache_pkg::dc_addr_u    addr;
    logic                    wr;      // 1 = store
    logic [3:0]              wstrb;
    logic [31:0]             wdata;
    logic                    is_op;
    dcache_pkg::cache_op_e   op;
    logic                    suc;     // strongly-ordered uncached

    modport buffer (input we, output addr, wr, wstrb, wdata, is_op, op, suc);
    modport ctrl   (output we, input addr, wr, wstrb, wdata, is_op, op, suc);
    modport array  (input addr, wstrb, wdata);
endinterface

interface array_if;
    // controller side
    logic [`DC_WAYS-1:0]  data_we;
    logic                 replace;    // full line write from memory
    logic [`DC_WAYS-1:0]  inval;
    logic [`DC_WAYS-1:0]  use_way;    // lru moves away from this way
    logic                 rd_index;   // latch read index from the pipeline

    // array side
    logic [`DC_WAYS-1:0]  hit;
    logic                 lru_way;
    logic [31:0]          hit_word;
    logic [31:0]          line_word;  // word out of the refill line
    logic [`DC_TAG_W:0]   tag_way0;   // {valid, tag}
    logic [`DC_TAG_W:0]   tag_way1;

    modport ctrl (
        output data_we, replace, inval, use_way, rd_index,
        input  hit, lru_way, hit_word, line_word, tag_way0, tag_way1
    );
    modport arrays (
        input  data_we, replace, inval, use_way, rd_index,
        output hit, lru_way, hit_word, line_word, tag_way0, tag_way1
    );
endinterface

`default_nettype wire

//--- dcache_pkg.sv
// shared types for the data cache
// address views, cache-op codes and controller states
`default_nettype none
`include "dcache_settings.svh"

package dcache_pkg;

    // one address word, read either as a memory address or as a cache-op target
    typedef union packed {
        struct packed {
            logic [`DC_TAG_W-1:0]    tag;
            logic [`DC_INDEX_W-1:0]  index;
            logic [`DC_OFFSET_W-1:0] word;
            logic [1:0]              byte_off;
        } mem;
        struct packed {
            logic [`DC_TAG_W-1:0]    hi;      // ignored by index ops
            logic [`DC_INDEX_W-1:0]  index;
            logic [`DC_OFFSET_W:0]   rsvd;
            logic                    way;     // target way for index forms
        } op;
    } dc_addr_u;

    // opcode bits 4:3
    typedef enum logic [1:0] {
        OP_INDEX_INIT  = 2'd0,
        OP_INDEX_INVAL = 2'd1,
        OP_HIT_INVAL   = 2'd2,
        OP_NOP         = 2'd3
    } cache_op_e;

    typedef enum logic [3:0] {
        ST_IDLE        = 4'd0,
        ST_LOOKUP      = 4'd1,
        ST_OP          = 4'd2,
        ST_HIT_W       = 4'd3,
        ST_MISS_R      = 4'd4,
        ST_MISS_R_WAIT = 4'd5,
        ST_MISS_W      = 4'd6
    } dc_state_e;

endpackage

`default_nettype wire

//--- dcache_reqbuf.sv
// request buffer, holds the accepted pipeline request and its uncached flag
`timescale 1ns/100ps
`default_nettype none
`include "dcache_settings.svh"

module dcache_reqbuf (
    input  wire                   clk,
    input  wire                   rstn,
    input  wire                   req_wr,
    input  wire                   req_is_op,
    input  wire [4:0]             req_opcode,
    input  wire [3:0]             req_wstrb,
    input  wire [`DC_ADDR_W-1:0]  req_addr,
    input  wire [31:0]            req_wdata,
    rbuf_if.buffer                rb
);

    logic suc_in;

    // top nibble selects the strongly-ordered window
    assign suc_in = (req_addr[`DC_ADDR_W-1 -: 4] == `DC_UNCACHED_HI);

    // request flags
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rb.wr    <= 1'b0;
            rb.is_op <= 1'b0;
            rb.suc   <= 1'b0;
        end else if (rb.we) begin
            rb.wr    <= req_wr;
            rb.is_op <= req_is_op;
            rb.suc   <= suc_in;   // worked out once here
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (rb.we) begin
            rb.addr  <= dcache_pkg::dc_addr_u'(req_addr);
            rb.wstrb <= req_wstrb;
            rb.wdata <= req_wdata;
            rb.op    <= dcache_pkg::cache_op_e'(req_opcode[4:3]);
        end
    end

endmodule

`default_nettype wire

//--- dcache_settings.svh
// size and address map macros for the two-way data cache
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// address layout, byte address split as tag | index | word | byte
`define DC_ADDR_W       32
`define DC_INDEX_W      4       // 16 sets
`define DC_OFFSET_W     2       // 4 words per line

// geometry
`define DC_WAYS         2       // hit and lru logic assume two ways
`define DC_LINE_W       128
`define DC_TAG_W        24      // addr minus index, word and byte bits

// strongly-ordered uncached window, top address nibble
`define DC_UNCACHED_HI  4'hA

`endif

//--- dcache_top.sv
// data cache top level with pipeline and memory ports
`timescale 1ns/100ps
`default_nettype none
`include "dcache_settings.svh"

module dcache_top (
    input  wire                   clk,
    input  wire                   rstn,
    // pipeline side
    input  wire                   req_valid,
    output logic                  req_ready,
    input  wire                   req_wr,
    input  wire                   req_is_op,
    input  wire [4:0]             req_opcode,
    input  wire [3:0]             req_wstrb,
    input  wire [`DC_ADDR_W-1:0]  req_addr,
    input  wire [31:0]            req_wdata,
    output logic                  rsp_valid,
    output logic [31:0]           rsp_rdata,
    // memory side
    output logic                  mem_req,
    output logic                  mem_wr,
    output logic [1:0]            mem_size,
    output logic [3:0]            mem_wstrb,
    output logic [`DC_ADDR_W-1:0] mem_addr,
    output logic [31:0]           mem_wdata,
    input  wire                   mem_addr_ok,
    input  wire                   mem_data_ok,
    input  wire [`DC_LINE_W-1:0]  mem_rdata
);

    rbuf_if  rb_if ();
    array_if ar_if ();

    dcache_reqbuf u_reqbuf (
        .clk        (clk),
        .rstn       (rstn),
        .req_wr     (req_wr),
        .req_is_op  (req_is_op),
        .req_opcode (req_opcode),
        .req_wstrb  (req_wstrb),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .rb         (rb_if.buffer)
    );

    dcache_arrays u_arrays (
        .clk        (clk),
        .rstn       (rstn),
        .req_addr   (req_addr),   // index read at acceptance
        .mem_rdata  (mem_rdata),
        .rb         (rb_if.array),
        .ar         (ar_if.arrays)
    );

    dcache_fsm u_fsm (
        .clk         (clk),
        .rstn        (rstn),
        .req_valid   (req_valid),
        .req_is_op   (req_is_op),
        .req_ready   (req_ready),
        .rsp_valid   (rsp_valid),
        .rsp_rdata   (rsp_rdata),
        .mem_req     (mem_req),
        .mem_wr      (mem_wr),
        .mem_size    (mem_size),
        .mem_wstrb   (mem_wstrb),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .rb          (rb_if.ctrl),
        .ar          (ar_if.ctrl)
    );

endmodule

`default_nettype wire

//--- tb_dcache.sv
// directed testbench for the data cache
// memory model, value check, watchdog and six tests
`timescale 1ns/100ps
`default_nettype none

module tb_dcache;

    localparam int TIMEOUT_NS = 6 * 200 * 4;

    logic         clk;
    logic         rstn;
    logic         req_valid;
    logic         req_ready;
    logic         req_wr;
    logic         req_is_op;
    logic [4:0]   req_opcode;
    logic [3:0]   req_wstrb;
    logic [31:0]  req_addr;
    logic [31:0]  req_wdata;
    logic         rsp_valid;
    logic [31:0]  rsp_rdata;
    logic         mem_req;
    logic         mem_wr;
    logic [1:0]   mem_size;
    logic [3:0]   mem_wstrb;
    logic [31:0]  mem_addr;
    logic [31:0]  mem_wdata;
    logic         mem_addr_ok;
    logic         mem_data_ok;
    logic [127:0] mem_rdata;

    logic [127:0] lines [logic [27:0]];   // model contents by line address
    integer       seed = 32'h591feba4;
    int           errors = 0;
    int           checks = 0;
    int           tests_run = 0;
    int           rd_count = 0;           // memory reads seen by the model
    int           wr_count = 0;
    logic [31:0]  last_waddr;
    logic [3:0]   last_wstrb;
    logic [31:0]  last_wdata;
    logic [1:0]   last_size;              // size of the last accepted request

    dcache_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin : watchdog
        #(TIMEOUT_NS + 40);
        $display("timeout, run did not finish, fsm state %s", dut_i.u_fsm.state.name());
        $display(">>> FAIL");
        $finish;
    end

    //////////////////////////////////////////////////
    // memory model
    //////////////////////////////////////////////////
    function automatic logic [31:0] merge_word(input logic [31:0] old_w,
                                               input logic [31:0] new_w,
                                               input logic [3:0] strb);
        logic [31:0] r;
        r = old_w;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) r[8*b +: 8] = new_w[8*b +: 8];
        end
        return r;
    endfunction

    function automatic logic [127:0] line_at(input logic [31:0] a);
        logic [127:0] l;
        if (lines.exists(a[31:4])) return lines[a[31:4]];
        for (int i = 0; i < 4; i++) begin
            l[32*i +: 32] = {a[31:4], 4'h0} + 32'(4 * i);   // word holds its own address
        end
        return l;
    endfunction

    initial begin : mem_model
        int unsigned wait_n;
        int          w;
        logic [31:0] a;
        logic [127:0] l;
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        mem_rdata   = '0;
        forever begin
            @(posedge clk);
            #1;
            mem_addr_ok = 1'b0;
            mem_data_ok = 1'b0;
            if (rstn && mem_req) begin
                wait_n = $unsigned($random(seed)) % 4;
                repeat (wait_n) begin
                    @(posedge clk);
                    #1;
                end
                a = mem_addr;
                w = int'(a[3:2]);
                last_size   = mem_size;
                mem_addr_ok = 1'b1;
                if (mem_wr) begin
                    wr_count++;
                    last_waddr = a;
                    last_wstrb = mem_wstrb;
                    last_wdata = mem_wdata;
                    l = line_at(a);
                    l[32*w +: 32] = merge_word(l[32*w +: 32], mem_wdata, mem_wstrb);
                    lines[a[31:4]] = l;
                end else begin
                    rd_count++;
                    @(posedge clk);
                    #1;
                    mem_addr_ok = 1'b0;
                    @(posedge clk);
                    #1;
                    mem_data_ok = 1'b1;    // aligned line, two cycles on
                    mem_rdata   = line_at(a);
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // drivers and checks
    //////////////////////////////////////////////////
    task automatic check_val(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            $display("ERR %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    // called at posedge + 1ns, returns just after the accepting edge
    task automatic send_req(input logic wr, input logic is_op, input logic [4:0] opcode,
                            input logic [3:0] strb, input logic [31:0] addr,
                            input logic [31:0] data);
        int n;
        n = 0;
        req_valid  = 1'b1;
        req_wr     = wr;
        req_is_op  = is_op;
        req_opcode = opcode;
        req_wstrb  = strb;
        req_addr   = addr;
        req_wdata  = data;
        @(negedge clk);
        while (!req_ready && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (!req_ready) begin
            $display("request to %h was never accepted", addr);
            errors++;
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic wait_rsp(output logic [31:0] data, output int lat);
        data = '0;
        @(negedge clk);
        lat = 1;
        while (!rsp_valid && lat < 200) begin
            @(negedge clk);
            lat++;
        end
        if (rsp_valid) begin
            data = rsp_rdata;
        end else begin
            $display("no read response within 200 cycles");
            errors++;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        @(negedge clk);
        while (!req_ready && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (!req_ready) begin
            $display("cache did not return to ready within 200 cycles");
            errors++;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic read_expect(input string name, input logic [31:0] addr,
                               input logic [31:0] expected, input logic expect_hit);
        logic [31:0] data;
        int          lat;
        int          rd0;
        rd0 = rd_count;
        send_req(1'b0, 1'b0, 5'd0, 4'h0, addr, 32'h0);
        wait_rsp(data, lat);
        check_val(name, expected, data);
        if (expect_hit) begin
            check_val({name, " latency"}, 1, lat);   // hit answers the next cycle
            check_val({name, " mem reads"}, 0, rd_count - rd0);
        end else begin
            check_val({name, " mem reads"}, 1, rd_count - rd0);
            check_val({name, " mem size"}, 2, last_size);   // word sized
        end
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [3:0] strb,
                              input logic [31:0] data);
        send_req(1'b1, 1'b0, 5'd0, strb, addr, data);
        wait_ready();
    endtask

    task automatic run_op(input dcache_pkg::cache_op_e op, input logic [31:0] addr);
        send_req(1'b0, 1'b1, {op, 3'b000}, 4'h0, addr, 32'h0);
        wait_ready();
    endtask

    task automatic end_test(input string name, input int err0);
        tests_run++;
        if (errors == err0) $display("test %s: ok", name);
        else                $display("test %s: %0d errors", name, errors - err0);
    endtask

    //////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////
    task automatic read_miss_then_hit();
        int err0;
        err0 = errors;
        read_expect("rd miss", 32'h0000_100C, 32'h0000_100C, 1'b0);
        read_expect("rd hit", 32'h0000_100C, 32'h0000_100C, 1'b1);
        end_test("read miss then hit", err0);
    endtask

    task automatic write_hit_through();
        int          err0;
        int          wr0;
        logic [31:0] merged;
        err0   = errors;
        wr0    = wr_count;
        merged = merge_word(32'h0000_1008, 32'hDEAD_BEEF, 4'b0011);
        write_word(32'h0000_1008, 4'b0011, 32'hDEAD_BEEF);
        check_val("wr hit mem writes", 1, wr_count - wr0);
        check_val("wr hit addr", 32'h0000_1008, last_waddr);
        check_val("wr hit strobe", 4'b0011, last_wstrb);
        check_val("wr hit data", 32'hDEAD_BEEF, last_wdata);
        check_val("wr hit size", 2, last_size);
        read_expect("wr hit readback", 32'h0000_1008, merged, 1'b1);
        end_test("write hit write-through", err0);
    endtask

    task automatic write_miss_no_alloc();
        int err0;
        int wr0;
        err0 = errors;
        wr0  = wr_count;
        write_word(32'h0000_2004, 4'hF, 32'h1234_5678);
        check_val("wr miss mem writes", 1, wr_count - wr0);
        check_val("wr miss data", 32'h1234_5678, last_wdata);
        read_expect("wr miss readback", 32'h0000_2004, 32'h1234_5678, 1'b0);
        end_test("write miss no allocate", err0);
    endtask

    task automatic uncached_region();
        int err0;
        int wr0;
        err0 = errors;
        wr0  = wr_count;
        read_expect("uc rd 1", 32'hA000_0010, 32'hA000_0010, 1'b0);
        read_expect("uc rd 2", 32'hA000_0010, 32'hA000_0010, 1'b0);
        write_word(32'hA000_0010, 4'hF, 32'hCAFE_F00D);
        check_val("uc wr mem writes", 1, wr_count - wr0);
        read_expect("uc rd after wr", 32'hA000_0010, 32'hCAFE_F00D, 1'b0);
        end_test("uncached region", err0);
    endtask

    task automatic cache_ops();
        int err0;
        err0 = errors;
        // sets 2 and 3 get both ways filled
        read_expect("op fill 3020", 32'h0000_3020, 32'h0000_3020, 1'b0);
        read_expect("op fill 4020", 32'h0000_4020, 32'h0000_4020, 1'b0);
        read_expect("op fill 5030", 32'h0000_5030, 32'h0000_5030, 1'b0);
        read_expect("op fill 6030", 32'h0000_6030, 32'h0000_6030, 1'b0);
        run_op(dcache_pkg::OP_HIT_INVAL, 32'h0000_3020);
        read_expect("hit-inval other way", 32'h0000_4020, 32'h0000_4020, 1'b1);
        read_expect("hit-inval line", 32'h0000_3020, 32'h0000_3020, 1'b0);
        run_op(dcache_pkg::OP_INDEX_INVAL, 32'h0000_0031);   // set 3, way 1
        read_expect("idx-inval other way", 32'h0000_5030, 32'h0000_5030, 1'b1);
        read_expect("idx-inval line", 32'h0000_6030, 32'h0000_6030, 1'b0);
        run_op(dcache_pkg::OP_INDEX_INIT, 32'h0000_0000);    // set 0, way 0
        read_expect("idx-init other way", 32'h0000_2004, 32'h1234_5678, 1'b1);
        read_expect("idx-init line", 32'h0000_1008, 32'h0000_BEEF, 1'b0);
        end_test("cache ops", err0);
    endtask

    task automatic lru_replace();
        int err0;
        int rd0;
        err0 = errors;
        rd0  = rd_count;
        read_expect("lru fill a", 32'h0000_7050, 32'h0000_7050, 1'b0);
        read_expect("lru fill b", 32'h0000_8050, 32'h0000_8050, 1'b0);
        read_expect("lru touch a", 32'h0000_7050, 32'h0000_7050, 1'b1);
        read_expect("lru fill c", 32'h0000_9050, 32'h0000_9050, 1'b0);
        read_expect("lru a kept", 32'h0000_7050, 32'h0000_7050, 1'b1);
        read_expect("lru b evicted", 32'h0000_8050, 32'h0000_8050, 1'b0);
        check_val("lru total mem reads", 4, rd_count - rd0);
        end_test("lru replacement", err0);
    endtask

    initial begin : main
        rstn       = 1'b0;
        req_valid  = 1'b0;
        req_wr     = 1'b0;
        req_is_op  = 1'b0;
        req_opcode = 5'd0;
        req_wstrb  = 4'h0;
        req_addr   = 32'h0;
        req_wdata  = 32'h0;
        repeat (10) @(posedge clk);
        #1;
        rstn = 1'b1;
        @(negedge clk);
        check_val("reset req_ready", 1, req_ready);
        check_val("reset mem_req", 0, mem_req);
        check_val("reset mem_wr", 0, mem_wr);
        check_val("reset rsp_valid", 0, rsp_valid);
        @(posedge clk);
        #1;
        read_miss_then_hit();
        write_hit_through();
        write_miss_no_alloc();
        uncached_region();
        cache_ops();
        lru_replace();
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
